// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench, pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module mips_tb -o mips_sim &&
./obj_dir/mips_sim | tee /dev/stderr | grep -q "^TEST OK$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== source/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath, register and bus width
`define MIPS_DATA_W 32

// Architectural registers, $zero included
`define MIPS_REG_COUNT 32

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// A fetch from this address stops the CPU
`define MIPS_HALT_ADDR 32'h00000000

// $v0, exported for observation
`define MIPS_V0_INDEX 2

// Link register written by JAL
`define MIPS_RA_INDEX 31

`endif

// ==== source/mips_cpu_bus.sv ====
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_cpu_bus import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    output logic                      active,
    output logic [`MIPS_DATA_W-1:0]   register_v0,
    output logic [`MIPS_DATA_W-1:0]   address,
    output logic                      write,
    output logic                      read,
    input  logic                      waitrequest,
    output logic [`MIPS_DATA_W-1:0]   writedata,
    output logic [`MIPS_DATA_W/8-1:0] byteenable,
    input  logic [`MIPS_DATA_W-1:0]   readdata
);

    instr_word_t             instr;
    exec_result_t            result;
    reg_write_t              reg_write;
    logic [`MIPS_DATA_W-1:0] pc;
    logic [`MIPS_DATA_W-1:0] rs_value;
    logic [`MIPS_DATA_W-1:0] rt_value;

    mips_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .result      (result),
        .instr       (instr),
        .pc          (pc),
        .reg_write   (reg_write),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable)
    );

    mips_regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .reg_write (reg_write),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .v0        (register_v0)
    );

    mips_execute u_execute (
        .instr    (instr),
        .pc       (pc),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .result   (result)
    );

endmodule

// ==== source/mips_execute.sv ====
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_execute import mips_pkg::*; (
    input  instr_word_t             instr,
    input  logic [`MIPS_DATA_W-1:0] pc,
    input  logic [`MIPS_DATA_W-1:0] rs_value,
    input  logic [`MIPS_DATA_W-1:0] rt_value,
    output exec_result_t            result
);

    logic [`MIPS_DATA_W-1:0] imm_sext;
    logic [`MIPS_DATA_W-1:0] imm_zext;
    logic [`MIPS_DATA_W-1:0] pc_plus4;
    logic [`MIPS_DATA_W-1:0] pc_plus8;
    logic [`MIPS_DATA_W-1:0] branch_offset;
    logic [`MIPS_DATA_W-1:0] jump_target;
    logic [`MIPS_DATA_W-1:0] effective_addr;
    logic [4:0]              shift_var;
    logic                    lt_signed;
    logic                    lt_unsigned;
    logic                    lt_signed_imm;
    logic                    lt_unsigned_imm;

    assign imm_sext = {{(`MIPS_DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {{(`MIPS_DATA_W-16){1'b0}}, instr.i.imm};

    assign pc_plus4 = pc + 4;
    assign pc_plus8 = pc + 8;

    assign branch_offset = {imm_sext[`MIPS_DATA_W-3:0], 2'b00};
    // J and JAL stay inside the 256 MB region of the delay slot
    assign jump_target = {pc_plus4[`MIPS_DATA_W-1:28], instr.j.index, 2'b00};

    assign effective_addr = rs_value + imm_sext;
    assign shift_var = rs_value[4:0];

    assign lt_signed = $signed(rs_value) < $signed(rt_value);
    assign lt_unsigned = rs_value < rt_value;
    assign lt_signed_imm = $signed(rs_value) < $signed(imm_sext);
    // SLTIU compares against the sign-extended immediate, unsigned
    assign lt_unsigned_imm = rs_value < imm_sext;

    always_comb begin
        result = '0;
        result.wb_index = instr.i.rt;
        result.branch_target = pc_plus4 + branch_offset;
        result.mem_address = {effective_addr[`MIPS_DATA_W-1:2], 2'b00};
        result.store_data = rt_value;

        case (instr.i.opcode)
            OP_RTYPE: begin
                result.wb_en = 1'b1;
                result.wb_index = instr.r.rd;
                case (instr.r.funct)
                    FN_SLL:  result.wb_value = rt_value << instr.r.shamt;
                    FN_SRL:  result.wb_value = rt_value >> instr.r.shamt;
                    FN_SRA:  result.wb_value = $signed(rt_value) >>> instr.r.shamt;
                    FN_SLLV: result.wb_value = rt_value << shift_var;
                    FN_SRLV: result.wb_value = rt_value >> shift_var;
                    FN_SRAV: result.wb_value = $signed(rt_value) >>> shift_var;
                    FN_ADDU: result.wb_value = rs_value + rt_value;
                    FN_SUBU: result.wb_value = rs_value - rt_value;
                    FN_AND:  result.wb_value = rs_value & rt_value;
                    FN_OR:   result.wb_value = rs_value | rt_value;
                    FN_XOR:  result.wb_value = rs_value ^ rt_value;
                    FN_SLT:  result.wb_value = {{(`MIPS_DATA_W-1){1'b0}}, lt_signed};
                    FN_SLTU: result.wb_value = {{(`MIPS_DATA_W-1){1'b0}}, lt_unsigned};
                    FN_JR: begin
                        result.wb_en = 1'b0;
                        result.branch_taken = 1'b1;
                        result.branch_target = rs_value;
                    end
                    FN_JALR: begin
                        result.wb_value = pc_plus8;
                        result.branch_taken = 1'b1;
                        result.branch_target = rs_value;
                    end
                    default: result.wb_en = 1'b0;
                endcase
            end

            OP_ADDIU: begin
                result.wb_en = 1'b1;
                result.wb_value = rs_value + imm_sext;
            end
            OP_SLTI: begin
                result.wb_en = 1'b1;
                result.wb_value = {{(`MIPS_DATA_W-1){1'b0}}, lt_signed_imm};
            end
            OP_SLTIU: begin
                result.wb_en = 1'b1;
                result.wb_value = {{(`MIPS_DATA_W-1){1'b0}}, lt_unsigned_imm};
            end
            // Logic immediates are zero extended
            OP_ANDI: begin
                result.wb_en = 1'b1;
                result.wb_value = rs_value & imm_zext;
            end
            OP_ORI: begin
                result.wb_en = 1'b1;
                result.wb_value = rs_value | imm_zext;
            end
            OP_XORI: begin
                result.wb_en = 1'b1;
                result.wb_value = rs_value ^ imm_zext;
            end
            OP_LUI: begin
                result.wb_en = 1'b1;
                result.wb_value = {instr.i.imm, {(`MIPS_DATA_W-16){1'b0}}};
            end

            OP_BEQ:  result.branch_taken = (rs_value == rt_value);
            OP_BNE:  result.branch_taken = (rs_value != rt_value);
            OP_BGTZ: result.branch_taken = ($signed(rs_value) > 0);
            OP_BLEZ: result.branch_taken = ($signed(rs_value) <= 0);

            OP_J: begin
                result.branch_taken = 1'b1;
                result.branch_target = jump_target;
            end
            OP_JAL: begin
                result.wb_en = 1'b1;
                result.wb_index = 5'(`MIPS_RA_INDEX);
                result.wb_value = pc_plus8;
                result.branch_taken = 1'b1;
                result.branch_target = jump_target;
            end

            // Load data is written later, in WRITE_BACK
            OP_LW:   result.mem_read = 1'b1;
            OP_SW:   result.mem_write = 1'b1;

            default: ;
        endcase
    end

endmodule

// ==== source/mips_pkg.sv ====
`include "mips_cfg.svh"

package mips_pkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_BLEZ  = 6'h06,
        OP_BGTZ  = 6'h07,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_SLTIU = 6'h0B,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        WRITE_BACK,
        HALTED
    } cpu_state_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] index;
    } j_fields_t;

    // One fetched word, seen in each of the three encodings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_word_t;

    typedef struct packed {
        logic                    wb_en;
        logic [4:0]              wb_index;
        logic [`MIPS_DATA_W-1:0] wb_value;
        logic                    branch_taken;
        logic [`MIPS_DATA_W-1:0] branch_target;
        logic                    mem_read;
        logic                    mem_write;
        logic [`MIPS_DATA_W-1:0] mem_address;
        logic [`MIPS_DATA_W-1:0] store_data;
    } exec_result_t;

    typedef struct packed {
        logic                    en;
        logic [4:0]              index;
        logic [`MIPS_DATA_W-1:0] value;
    } reg_write_t;

endpackage

// ==== source/mips_regfile.sv ====
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_regfile import mips_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  instr_word_t             instr,
    input  reg_write_t              reg_write,
    output logic [`MIPS_DATA_W-1:0] rs_value,
    output logic [`MIPS_DATA_W-1:0] rt_value,
    output logic [`MIPS_DATA_W-1:0] v0
);

    logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

    // Both source fields sit at the same place in R and I formats
    assign rs_value = regs[instr.r.rs];
    assign rt_value = regs[instr.r.rt];

    assign v0 = regs[`MIPS_V0_INDEX];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `MIPS_REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (reg_write.en && reg_write.index != '0) begin
            // $zero never takes a write, so it reads back as zero
            regs[reg_write.index] <= reg_write.value;
        end
    end

endmodule

// ==== source/mips_sequencer.sv ====
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_sequencer import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      waitrequest,
    input  logic [`MIPS_DATA_W-1:0]   readdata,
    input  exec_result_t              result,
    output instr_word_t               instr,
    output logic [`MIPS_DATA_W-1:0]   pc,
    output reg_write_t                reg_write,
    output logic                      active,
    output logic [`MIPS_DATA_W-1:0]   address,
    output logic                      read,
    output logic                      write,
    output logic [`MIPS_DATA_W-1:0]   writedata,
    output logic [`MIPS_DATA_W/8-1:0] byteenable
);

    cpu_state_t              state;
    instr_word_t             ir;
    logic                    stall;
    logic                    delay;
    logic [`MIPS_DATA_W-1:0] jump_target;
    logic                    bus_ready;
    logic                    mem_access;
    logic                    mem_wait;
    logic                    fetch_done;

    // Fetched word arrives on readdata, later cycles replay it from ir
    assign instr = (state == EXEC && !stall) ? instr_word_t'(readdata) : ir;

    assign mem_access = result.mem_read | result.mem_write;
    assign mem_wait = mem_access & waitrequest;
    assign fetch_done = (state == FETCH) & read & ~waitrequest;

    assign active = (state != HALTED);

    always_comb begin
        read = 1'b0;
        write = 1'b0;
        address = pc;
        writedata = result.store_data;
        byteenable = '0;
        case (state)
            // No fetch while reset is still asserted
            FETCH: read = bus_ready;
            EXEC: begin
                read = result.mem_read;
                write = result.mem_write;
                address = result.mem_address;
            end
            default: ;
        endcase
        if (read || write) begin
            byteenable = '1;
        end
    end

    always_comb begin
        reg_write = '0;
        if (state == EXEC && !mem_wait) begin
            reg_write.en = result.wb_en;
            reg_write.index = result.wb_index;
            reg_write.value = result.wb_value;
        end else if (state == WRITE_BACK) begin
            reg_write.en = 1'b1;
            reg_write.index = ir.i.rt;
            reg_write.value = readdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc <= `MIPS_RESET_VECTOR;
            stall <= 1'b0;
            delay <= 1'b0;
            bus_ready <= 1'b0;
        end else begin
            bus_ready <= 1'b1;
            case (state)
                FETCH: begin
                    // The fetch from the halt address completes, then the CPU stops
                    if (fetch_done) begin
                        state <= (pc == `MIPS_HALT_ADDR) ? HALTED : EXEC;
                    end
                end
                EXEC: begin
                    ir <= instr;
                    if (mem_wait) begin
                        stall <= 1'b1;
                    end else begin
                        stall <= 1'b0;
                        state <= result.mem_read ? WRITE_BACK : FETCH;
                        // Delay slot done, so the recorded target takes effect
                        pc <= delay ? jump_target : pc + 4;
                        delay <= result.branch_taken;
                        if (result.branch_taken) begin
                            jump_target <= result.branch_target;
                        end
                    end
                end
                WRITE_BACK: state <= FETCH;
                default: state <= HALTED;
            endcase
        end
    end

endmodule

// ==== sources.f ====
+incdir+source
source/mips_pkg.sv
source/mips_regfile.sv
source/mips_execute.sv
source/mips_sequencer.sv
source/mips_cpu_bus.sv
verification/mips_assertions.sv
verification/mips_tb.sv

// ==== verification/mips_assertions.sv ====
`timescale 1ns/100ps

module mips_assertions (
    input logic        clk,
    input logic        reset,
    input logic        active,
    input logic        read,
    input logic        write,
    input logic        waitrequest,
    input logic [31:0] address,
    input logic [31:0] writedata
);

    // A bus cycle is either a read or a write
    read_write_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(read && write)
    ) else $error("read and write asserted together");

    // A stalled access holds its request until waitrequest drops
    held_access_stable: assert property (
        @(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(read) && $stable(write) && $stable(address)
            && (!write || $stable(writedata))
    ) else $error("access changed while waitrequest was high");

    halted_bus_idle: assert property (
        @(posedge clk) disable iff (reset) !active |-> !read && !write
    ) else $error("bus access while the CPU is halted");

endmodule

bind mips_cpu_bus mips_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .address     (address),
    .writedata   (writedata)
);

// ==== verification/mips_tb.sv ====
`timescale 1ns/100ps
`include "mips_cfg.svh"

module mips_tb import mips_pkg::*; ();

    localparam logic [31:0] BASE = `MIPS_RESET_VECTOR;
    localparam logic [31:0] DATA_BASE = 32'h0000_1000;
    localparam int DATA_WORDS = 16;
    localparam int NUM_TESTS = 9;
    localparam int TIMEOUT = 5000;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] model_dmem [logic [31:0]];
    logic [31:0] model_regs [32];
    logic [31:0] prog [$];

    // Memory model state
    bit          busy;
    bit          done_pend;
    bit          done_write;
    int          wait_left;
    logic [31:0] done_addr;
    logic [31:0] done_data;
    logic [3:0]  done_be;
    logic [31:0] mem_word;
    bit          first_read_seen;
    int          late_accesses;
    int          errors;

    mips_cpu_bus dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return {addr[15:0], ~addr[31:16]} ^ 32'h5a5a_3c3c;
    endfunction

    task automatic report_fail(string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // Wait states are chosen when an access starts; data moves after it completes
    always @(negedge clk) begin
        if (reset) begin
            busy = 0;
            done_pend = 0;
            waitrequest = 1'b0;
        end else begin
            if (done_pend) begin
                done_pend = 0;
                mem_word = mem.exists(done_addr) ? mem[done_addr] : fill_word(done_addr);
                if (done_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (done_be[b]) begin
                            mem_word[8*b +: 8] = done_data[8*b +: 8];
                        end
                    end
                    mem[done_addr] = mem_word;
                end else begin
                    readdata = mem_word;
                end
            end
            // A fresh instruction word changes the request, so let the DUT settle
            #1;
            if (read && !first_read_seen) begin
                first_read_seen = 1;
                if (address != BASE || !active) begin
                    report_fail($sformatf("first fetch at %h, active %b", address, active));
                end
            end
            if (!active && (read || write)) begin
                late_accesses++;
            end
            if (read || write) begin
                if (!busy) begin
                    busy = 1;
                    wait_left = int'($urandom % 4);
                end
                if (wait_left > 0) begin
                    waitrequest = 1'b1;
                    wait_left--;
                end else begin
                    waitrequest = 1'b0;
                    busy = 0;
                    done_pend = 1;
                    done_write = write;
                    done_addr = address;
                    done_data = writedata;
                    done_be = byteenable;
                end
            end else begin
                waitrequest = 1'b0;
            end
        end
    end

    function automatic logic [31:0] enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [4:0] sh, funct_t fn);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(opcode_t op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] pick_dest();
        return 5'(2 + $urandom % 8);
    endfunction

    function automatic logic [4:0] pick_src();
        return 5'($urandom % 10);
    endfunction

    task automatic emit_alu();
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        rd = pick_dest();
        rs = pick_src();
        rt = pick_src();
        imm = 16'($urandom);
        case ($urandom % 20)
            0: prog.push_back(enc_r(rs, rt, rd, 0, FN_ADDU));
            1: prog.push_back(enc_r(rs, rt, rd, 0, FN_SUBU));
            2: prog.push_back(enc_r(rs, rt, rd, 0, FN_AND));
            3: prog.push_back(enc_r(rs, rt, rd, 0, FN_OR));
            4: prog.push_back(enc_r(rs, rt, rd, 0, FN_XOR));
            5: prog.push_back(enc_r(rs, rt, rd, 0, FN_SLT));
            6: prog.push_back(enc_r(rs, rt, rd, 0, FN_SLTU));
            7: prog.push_back(enc_r(0, rt, rd, imm[4:0], FN_SLL));
            8: prog.push_back(enc_r(0, rt, rd, imm[4:0], FN_SRL));
            9: prog.push_back(enc_r(0, rt, rd, imm[4:0], FN_SRA));
            10: prog.push_back(enc_r(rs, rt, rd, 0, FN_SLLV));
            11: prog.push_back(enc_r(rs, rt, rd, 0, FN_SRLV));
            12: prog.push_back(enc_r(rs, rt, rd, 0, FN_SRAV));
            13: prog.push_back(enc_i(OP_ADDIU, rs, rd, imm));
            14: prog.push_back(enc_i(OP_ANDI, rs, rd, imm));
            15: prog.push_back(enc_i(OP_ORI, rs, rd, imm));
            16: prog.push_back(enc_i(OP_XORI, rs, rd, imm));
            17: prog.push_back(enc_i(OP_SLTI, rs, rd, imm));
            18: prog.push_back(enc_i(OP_SLTIU, rs, rd, imm));
            default: prog.push_back(enc_i(OP_LUI, 0, rd, imm));
        endcase
    endtask

    // Absolute offsets from $zero keep every access inside the data region
    task automatic emit_mem();
        logic [15:0] off;
        off = 16'(DATA_BASE + 4 * ($urandom % DATA_WORDS));
        if ($urandom % 2 == 0) begin
            prog.push_back(enc_i(OP_LW, 0, pick_dest(), off));
        end else begin
            prog.push_back(enc_i(OP_SW, 0, pick_src(), off));
        end
    endtask

    // Forward transfer, a plain delay slot, then the skipped instructions
    task automatic emit_branch();
        int          skip;
        int          target;
        logic [31:0] taddr;
        logic [4:0]  r;
        skip = int'($urandom % 4);
        target = prog.size() + 2 + skip;
        taddr = BASE + 32'(4 * target);
        r = pick_dest();
        case ($urandom % 7)
            0: prog.push_back(enc_i(OP_BEQ, pick_src(), pick_src(), 16'(1 + skip)));
            1: prog.push_back(enc_i(OP_BNE, pick_src(), pick_src(), 16'(1 + skip)));
            2: prog.push_back(enc_i(OP_BGTZ, pick_src(), 0, 16'(1 + skip)));
            3: prog.push_back(enc_i(OP_BLEZ, pick_src(), 0, 16'(1 + skip)));
            4: prog.push_back({OP_J, taddr[27:2]});
            5: prog.push_back({OP_JAL, taddr[27:2]});
            default: begin
                taddr = taddr + 8;
                prog.push_back(enc_i(OP_LUI, 0, r, taddr[31:16]));
                prog.push_back(enc_i(OP_ORI, r, r, taddr[15:0]));
                prog.push_back(enc_r(r, 0, pick_dest(), 0, FN_JALR));
            end
        endcase
        emit_alu();
        repeat (skip) emit_alu();
    endtask

    task automatic gen_program(int kind);
        logic [4:0] r;
        prog.delete();
        for (int k = 2; k <= 9; k++) begin
            r = 5'(k);
            prog.push_back(enc_i(OP_LUI, 0, r, 16'($urandom)));
            prog.push_back(enc_i(OP_ORI, r, r, 16'($urandom)));
        end
        while (prog.size() < 56) begin
            if (kind == 2 && $urandom % 3 == 0) begin
                emit_branch();
            end else if (kind >= 1 && $urandom % 3 == 0) begin
                emit_mem();
            end else begin
                emit_alu();
            end
        end
        // Fold the other registers into $v0 so their values show up
        for (int k = 3; k <= 9; k++) begin
            prog.push_back(enc_r(2, 5'(k), 2, 0, FN_XOR));
        end
        prog.push_back(enc_r(2, 31, 2, 0, FN_XOR));
        prog.push_back(enc_r(0, 0, 0, 0, FN_JR));
        prog.push_back(32'h0);
    endtask

    task automatic load_memory();
        logic [31:0] a;
        mem.delete();
        model_dmem.delete();
        foreach (prog[i]) begin
            mem[BASE + 32'(4 * i)] = prog[i];
        end
        for (int w = 0; w < DATA_WORDS; w++) begin
            a = DATA_BASE + 32'(4 * w);
            mem[a] = $urandom;
            model_dmem[a] = mem[a];
        end
    endtask

    task automatic set_reg(logic [4:0] idx, logic [31:0] value);
        if (idx != 0) begin
            model_regs[idx] = value;
        end
    endtask

    // Instruction-level reference with one pending delayed transfer
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] tgt;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        bit          pend;
        int          steps;
        int          idx;
        foreach (model_regs[k]) model_regs[k] = '0;
        pc = BASE;
        tgt = '0;
        pend = 0;
        steps = 0;
        while (pc != `MIPS_HALT_ADDR && steps < 2000) begin
            idx = int'((pc - BASE) >> 2);
            if (idx < 0 || idx >= prog.size()) begin
                $display("Reference model left the program at pc %h", pc);
                errors++;
                return;
            end
            w = prog[idx];
            rt = w[20:16];
            rd = w[15:11];
            sh = w[10:6];
            a = model_regs[w[25:21]];
            b = model_regs[rt];
            imm_s = {{16{w[15]}}, w[15:0]};
            imm_z = {16'h0, w[15:0]};
            next_pc = pend ? tgt : pc + 4;
            pend = 0;
            case (opcode_t'(w[31:26]))
                OP_RTYPE: case (funct_t'(w[5:0]))
                    FN_SLL:  set_reg(rd, b << sh);
                    FN_SRL:  set_reg(rd, b >> sh);
                    FN_SRA:  set_reg(rd, $signed(b) >>> sh);
                    FN_SLLV: set_reg(rd, b << a[4:0]);
                    FN_SRLV: set_reg(rd, b >> a[4:0]);
                    FN_SRAV: set_reg(rd, $signed(b) >>> a[4:0]);
                    FN_ADDU: set_reg(rd, a + b);
                    FN_SUBU: set_reg(rd, a - b);
                    FN_AND:  set_reg(rd, a & b);
                    FN_OR:   set_reg(rd, a | b);
                    FN_XOR:  set_reg(rd, a ^ b);
                    FN_SLT:  set_reg(rd, {31'h0, $signed(a) < $signed(b)});
                    FN_SLTU: set_reg(rd, {31'h0, a < b});
                    FN_JR: begin
                        pend = 1;
                        tgt = a;
                    end
                    FN_JALR: begin
                        set_reg(rd, pc + 8);
                        pend = 1;
                        tgt = a;
                    end
                    default: ;
                endcase
                OP_ADDIU: set_reg(rt, a + imm_s);
                OP_SLTI:  set_reg(rt, {31'h0, $signed(a) < $signed(imm_s)});
                OP_SLTIU: set_reg(rt, {31'h0, a < imm_s});
                OP_ANDI:  set_reg(rt, a & imm_z);
                OP_ORI:   set_reg(rt, a | imm_z);
                OP_XORI:  set_reg(rt, a ^ imm_z);
                OP_LUI:   set_reg(rt, {w[15:0], 16'h0});
                OP_LW:    set_reg(rt, model_dmem[a + imm_s]);
                OP_SW:    model_dmem[a + imm_s] = b;
                OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
                    case (opcode_t'(w[31:26]))
                        OP_BEQ:  pend = (a == b);
                        OP_BNE:  pend = (a != b);
                        OP_BGTZ: pend = ($signed(a) > 0);
                        default: pend = ($signed(a) <= 0);
                    endcase
                    tgt = pc + 4 + {imm_s[29:0], 2'b00};
                end
                OP_J, OP_JAL: begin
                    if (w[31:26] == OP_JAL) set_reg(31, pc + 8);
                    pend = 1;
                    tgt = {pc[31:28], w[25:0], 2'b00};
                end
                default: ;
            endcase
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic wait_halt(output bit halted);
        int cycles;
        cycles = 0;
        while (active && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        halted = !active;
        if (!halted) begin
            $display("Timeout: the CPU did not halt within %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic check_results();
        if (register_v0 !== model_regs[2]) begin
            report_fail($sformatf("register_v0 %h, expected %h", register_v0, model_regs[2]));
        end
        foreach (model_dmem[a]) begin
            if (mem[a] !== model_dmem[a]) begin
                report_fail($sformatf("memory at %h is %h, expected %h", a, mem[a],
                                      model_dmem[a]));
            end
        end
        late_accesses = 0;
        repeat (20) @(negedge clk);
        if (active || late_accesses != 0) begin
            report_fail($sformatf("after halt active %b, %0d accesses", active, late_accesses));
        end
    endtask

    initial begin
        int  errors_before;
        bit  halted;
        string names [3];
        names = '{"alu", "memory", "branch"};
        void'($urandom(32'h76d3680b));
        clk = 1'b0;
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = '0;
        errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errors_before = errors;
            reset = 1'b1;
            gen_program(t % 3);
            load_memory();
            run_model();
            first_read_seen = 0;
            repeat (16) @(negedge clk);
            reset = 1'b0;
            wait_halt(halted);
            if (halted) begin
                check_results();
            end
            $display("test %0d %s: %s", t, names[t % 3],
                     (errors == errors_before) ? "pass" : "fail");
        end
        $display("%0d tests run, %0d errors", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
